//--- decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import mipsPkg::*;
(
    input  wire logic     i_clk,
    input  wire logic     i_arstN,
    input  wire word_t    i_ifPc4,
    input  wire word_t    i_ifInstr,
    input  wire logic     i_wbWrite,
    input  wire regAddr_t i_wbReg,
    input  wire word_t    i_wbData,
    output logic          o_jump,
    output word_t         o_jumpTarget,
    output idEx_t         o_idEx
);

    opcode_t  opcode;
    regAddr_t rsAddr;
    regAddr_t rtAddr;
    regAddr_t rdAddr;
    regAddr_t shamt;
    funct_t   functSel;
    word_t    rsData;
    word_t    rtData;
    word_t    immExt;
    logic     logicImm;
    exCtrl_t  exCtrl;
    memCtrl_t memCtrl;
    wbCtrl_t  wbCtrl;

    assign opcode = i_ifInstr[31:26];
    assign rsAddr = i_ifInstr[25:21];
    assign rtAddr = i_ifInstr[20:16];
    assign rdAddr = i_ifInstr[15:11];
    assign shamt  = i_ifInstr[10:6];

    //////////////////////////////////////////////////
    // Main control
    always_comb begin
        exCtrl  = '0;
        memCtrl = '0;
        wbCtrl  = '0;
        o_jump  = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                exCtrl.regDst   = 1'b1;
                exCtrl.aluOp    = ALUOP_RTYPE;
                wbCtrl.regWrite = 1'b1;
            end
            OP_ADDI: begin
                exCtrl.aluSrc   = 1'b1;
                exCtrl.aluOp    = ALUOP_ADD;
                wbCtrl.regWrite = 1'b1;
            end
            OP_ANDI, OP_ORI: begin
                exCtrl.aluSrc   = 1'b1;
                exCtrl.aluOp    = ALUOP_LOGIC;
                wbCtrl.regWrite = 1'b1;
            end
            OP_LW: begin
                exCtrl.aluSrc   = 1'b1;
                exCtrl.aluOp    = ALUOP_ADD;
                memCtrl.memRead = 1'b1;
                wbCtrl.memToReg = 1'b1;
                wbCtrl.regWrite = 1'b1;
            end
            OP_SW: begin
                exCtrl.aluSrc    = 1'b1;
                exCtrl.aluOp     = ALUOP_ADD;
                memCtrl.memWrite = 1'b1;
            end
            OP_BEQ: begin
                exCtrl.aluOp   = ALUOP_SUB;
                memCtrl.branch = 1'b1;
            end
            OP_J: begin
                o_jump = 1'b1;
            end
            default: begin
                o_jump = 1'b0;
            end
        endcase
    end

    // Logical immediates zero-extend, all others sign-extend
    assign logicImm = (opcode == OP_ANDI) || (opcode == OP_ORI);
    assign immExt   = logicImm ? {16'b0, i_ifInstr[15:0]}
                               : {{16{i_ifInstr[15]}}, i_ifInstr[15:0]};

    // andi and ori borrow the R-type funct so execute sees one code
    always_comb begin
        case (opcode)
            OP_ANDI: functSel = FN_AND;
            OP_ORI:  functSel = FN_OR;
            default: functSel = i_ifInstr[5:0];
        endcase
    end

    assign o_jumpTarget = {i_ifPc4[31:28], i_ifInstr[25:0], 2'b00};

    regFile uRegFile (
        .i_clk    (i_clk),
        .i_arstN  (i_arstN),
        .i_rsAddr (rsAddr),
        .i_rtAddr (rtAddr),
        .i_wrEn   (i_wbWrite),
        .i_wrAddr (i_wbReg),
        .i_wrData (i_wbData),
        .o_rsData (rsData),
        .o_rtData (rtData)
    );

    //////////////////////////////////////////////////
    // ID/EX
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_idEx <= '0;
        end else begin
            o_idEx.pc4   <= i_ifPc4;
            o_idEx.rsVal <= rsData;
            o_idEx.rtVal <= rtData;
            o_idEx.imm   <= immExt;
            o_idEx.rt    <= rtAddr;
            o_idEx.rd    <= rdAddr;
            o_idEx.shamt <= shamt;
            o_idEx.funct <= functSel;
            o_idEx.ex    <= exCtrl;
            o_idEx.mem   <= memCtrl;
            o_idEx.wb    <= wbCtrl;
        end
    end

endmodule

`default_nettype wire

//--- executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import mipsPkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_arstN,
    input  wire idEx_t i_idEx,
    output exMem_t     o_exMem
);

    aluCtrl_t aluCtrl;
    aluCtrl_t functCtrl;
    word_t    opA;
    word_t    opB;
    word_t    aluResult;
    word_t    branchTarget;
    regAddr_t dest;
    logic     zero;

    //////////////////////////////////////////////////
    // ALU control
    always_comb begin
        case (i_idEx.funct)
            FN_ADD:  functCtrl = ALU_ADD;
            FN_SUB:  functCtrl = ALU_SUB;
            FN_AND:  functCtrl = ALU_AND;
            FN_OR:   functCtrl = ALU_OR;
            FN_XOR:  functCtrl = ALU_XOR;
            FN_SLT:  functCtrl = ALU_SLT;
            FN_SLL:  functCtrl = ALU_SLL;
            FN_SRL:  functCtrl = ALU_SRL;
            default: functCtrl = ALU_ADD;
        endcase
    end

    always_comb begin
        case (i_idEx.ex.aluOp)
            ALUOP_ADD:   aluCtrl = ALU_ADD;
            ALUOP_SUB:   aluCtrl = ALU_SUB;
            ALUOP_RTYPE: aluCtrl = functCtrl;
            default:     aluCtrl = (i_idEx.funct == FN_OR) ? ALU_OR : ALU_AND;
        endcase
    end

    //////////////////////////////////////////////////
    // ALU
    assign opA = i_idEx.rsVal;
    assign opB = i_idEx.ex.aluSrc ? i_idEx.imm : i_idEx.rtVal;

    always_comb begin
        case (aluCtrl)
            ALU_ADD: aluResult = opA + opB;
            ALU_SUB: aluResult = opA - opB;
            ALU_AND: aluResult = opA & opB;
            ALU_OR:  aluResult = opA | opB;
            ALU_XOR: aluResult = opA ^ opB;
            ALU_SLT: aluResult = word_t'($signed(opA) < $signed(opB));
            // Constant shifts act on rt
            ALU_SLL: aluResult = opB << i_idEx.shamt;
            ALU_SRL: aluResult = opB >> i_idEx.shamt;
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // Word offset from the instruction after the branch
    assign branchTarget = i_idEx.pc4 + {i_idEx.imm[29:0], 2'b00};

    assign dest = i_idEx.ex.regDst ? i_idEx.rd : i_idEx.rt;

    // EX/MEM
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_exMem <= '0;
        end else begin
            o_exMem.branchTarget <= branchTarget;
            o_exMem.zero         <= zero;
            o_exMem.aluResult    <= aluResult;
            o_exMem.storeData    <= i_idEx.rtVal;
            o_exMem.dest         <= dest;
            o_exMem.mem          <= i_idEx.mem;
            o_exMem.wb           <= i_idEx.wb;
        end
    end

endmodule

`default_nettype wire

//--- fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCpu_config.svh"

module fetchStage
    import mipsPkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_arstN,
    input  wire logic      i_run,
    input  wire logic      i_imemWe,
    input  wire imemAddr_t i_imemAddr,
    input  wire word_t     i_imemData,
    input  wire logic      i_jump,
    input  wire word_t     i_jumpTarget,
    input  wire logic      i_pcSrc,
    input  wire word_t     i_branchTarget,
    output word_t          o_ifPc4,
    output word_t          o_ifInstr
);

    word_t     pc;
    word_t     pc4;
    word_t     pcNext;
    word_t     instr;
    imemAddr_t fetchIdx;
    word_t     imem [`IMEM_DEPTH];

    assign pc4 = pc + word_t'(4);

    // Jump from decode wins over a branch from memory
    always_comb begin
        if (i_jump) begin
            pcNext = i_jumpTarget;
        end else if (i_pcSrc) begin
            pcNext = i_branchTarget;
        end else begin
            pcNext = pc4;
        end
    end

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            pc <= '0;
        end else if (i_run) begin
            pc <= pcNext;
        end
    end

    //////////////////////////////////////////////////
    // Instruction memory, written by the load port
    always_ff @(posedge i_clk) begin
        if (i_imemWe) begin
            imem[i_imemAddr] <= i_imemData;
        end
    end

    assign fetchIdx = pc[`IMEM_ADDR_WIDTH+1:2];
    assign instr    = imem[fetchIdx];

    // IF/ID, bubbles in the zero instruction while halted
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_ifPc4   <= '0;
            o_ifInstr <= '0;
        end else begin
            o_ifPc4   <= pc4;
            o_ifInstr <= i_run ? instr : '0;
        end
    end

endmodule

`default_nettype wire

//--- memWbStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCpu_config.svh"

module memWbStage
    import mipsPkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_arstN,
    input  wire exMem_t i_exMem,
    output logic        o_pcSrc,
    output word_t       o_branchTarget,
    output logic        o_wbWrite,
    output regAddr_t    o_wbReg,
    output word_t       o_wbData
);

    localparam int DMEM_ADDR_WIDTH = $clog2(`DMEM_DEPTH);

    logic [DMEM_ADDR_WIDTH-1:0] memIdx;
    word_t                      loadData;
    word_t                      dmem [`DMEM_DEPTH];
    memWb_t                     memWb;

    // Branch decision feeds straight back to fetch
    assign o_pcSrc        = i_exMem.mem.branch & i_exMem.zero;
    assign o_branchTarget = i_exMem.branchTarget;

    //////////////////////////////////////////////////
    // Data memory, word addressed
    assign memIdx = i_exMem.aluResult[DMEM_ADDR_WIDTH+1:2];

    always_ff @(posedge i_clk) begin
        if (i_exMem.mem.memWrite) begin
            dmem[memIdx] <= i_exMem.storeData;
        end
    end

    assign loadData = i_exMem.mem.memRead ? dmem[memIdx] : '0;

    // MEM/WB
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            memWb <= '0;
        end else begin
            memWb.aluResult <= i_exMem.aluResult;
            memWb.loadData  <= loadData;
            memWb.dest      <= i_exMem.dest;
            memWb.wb        <= i_exMem.wb;
        end
    end

    // Writeback, r0 targets are dropped here
    assign o_wbWrite = memWb.wb.regWrite && (memWb.dest != '0);
    assign o_wbReg   = memWb.dest;
    assign o_wbData  = memWb.wb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

`default_nettype wire

//--- mipsCpu.f
+incdir+.
mipsPkg.sv
regFile.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
mipsCpu.sv
tbClock.sv
tbMipsCpu.sv

//--- mipsCpu.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCpu
    import mipsPkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_arstN,
    input  wire logic      i_run,
    input  wire logic      i_imemWe,
    input  wire imemAddr_t i_imemAddr,
    input  wire word_t     i_imemData,
    output logic           o_wbValid,
    output regAddr_t       o_wbReg,
    output word_t          o_wbData
);

    word_t  ifPc4;
    word_t  ifInstr;
    logic   jump;
    word_t  jumpTarget;
    logic   pcSrc;
    word_t  branchTarget;
    idEx_t  idEx;
    exMem_t exMem;
    logic   wbWrite;

    //////////////////////////////////////////////////
    // Fetch and decode
    fetchStage uFetch (
        .i_clk          (i_clk),
        .i_arstN        (i_arstN),
        .i_run          (i_run),
        .i_imemWe       (i_imemWe),
        .i_imemAddr     (i_imemAddr),
        .i_imemData     (i_imemData),
        .i_jump         (jump),
        .i_jumpTarget   (jumpTarget),
        .i_pcSrc        (pcSrc),
        .i_branchTarget (branchTarget),
        .o_ifPc4        (ifPc4),
        .o_ifInstr      (ifInstr)
    );

    decodeStage uDecode (
        .i_clk        (i_clk),
        .i_arstN      (i_arstN),
        .i_ifPc4      (ifPc4),
        .i_ifInstr    (ifInstr),
        .i_wbWrite    (wbWrite),
        .i_wbReg      (o_wbReg),
        .i_wbData     (o_wbData),
        .o_jump       (jump),
        .o_jumpTarget (jumpTarget),
        .o_idEx       (idEx)
    );

    //////////////////////////////////////////////////
    // Execute, memory and writeback
    executeStage uExecute (
        .i_clk   (i_clk),
        .i_arstN (i_arstN),
        .i_idEx  (idEx),
        .o_exMem (exMem)
    );

    memWbStage uMemWb (
        .i_clk          (i_clk),
        .i_arstN        (i_arstN),
        .i_exMem        (exMem),
        .o_pcSrc        (pcSrc),
        .o_branchTarget (branchTarget),
        .o_wbWrite      (wbWrite),
        .o_wbReg        (o_wbReg),
        .o_wbData       (o_wbData)
    );

    // Already qualified for a nonzero destination
    assign o_wbValid = wbWrite;

endmodule

`default_nettype wire

//--- mipsCpu_config.svh
`ifndef MIPSCPU_CONFIG_SVH
`define MIPSCPU_CONFIG_SVH

// Datapath and register file geometry
`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5
`define NUM_REGS        32

// Memory sizes in words
`define IMEM_DEPTH      256
`define DMEM_DEPTH      256
`define IMEM_ADDR_WIDTH 8

`endif

//--- mipsPkg.sv
`default_nettype none

`include "mipsCpu_config.svh"

package mipsPkg;

    typedef logic [`WORD_WIDTH-1:0]      word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0]  regAddr_t;
    typedef logic [`IMEM_ADDR_WIDTH-1:0] imemAddr_t;
    typedef logic [5:0]                  opcode_t;
    typedef logic [5:0]                  funct_t;
    typedef logic [1:0]                  aluOp_t;
    typedef logic [3:0]                  aluCtrl_t;

    //////////////////////////////////////////////////
    // Instruction encodings
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ANDI  = 6'h0C;
    localparam opcode_t OP_ORI   = 6'h0D;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2B;

    localparam funct_t FN_SLL = 6'h00;
    localparam funct_t FN_SRL = 6'h02;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_XOR = 6'h26;
    localparam funct_t FN_SLT = 6'h2A;

    // Main control ALU classes
    localparam aluOp_t ALUOP_ADD   = 2'd0;
    localparam aluOp_t ALUOP_SUB   = 2'd1;
    localparam aluOp_t ALUOP_RTYPE = 2'd2;
    localparam aluOp_t ALUOP_LOGIC = 2'd3;

    // ALU operations
    localparam aluCtrl_t ALU_ADD = 4'd0;
    localparam aluCtrl_t ALU_SUB = 4'd1;
    localparam aluCtrl_t ALU_AND = 4'd2;
    localparam aluCtrl_t ALU_OR  = 4'd3;
    localparam aluCtrl_t ALU_XOR = 4'd4;
    localparam aluCtrl_t ALU_SLT = 4'd5;
    localparam aluCtrl_t ALU_SLL = 4'd6;
    localparam aluCtrl_t ALU_SRL = 4'd7;

    //////////////////////////////////////////////////
    // Control groups, consumed one stage at a time
    typedef struct packed {
        logic   aluSrc;
        aluOp_t aluOp;
        logic   regDst;
    } exCtrl_t;

    typedef struct packed {
        logic branch;
        logic memRead;
        logic memWrite;
    } memCtrl_t;

    typedef struct packed {
        logic memToReg;
        logic regWrite;
    } wbCtrl_t;

    //////////////////////////////////////////////////
    // Pipeline registers
    typedef struct packed {
        word_t    pc4;
        word_t    rsVal;
        word_t    rtVal;
        word_t    imm;
        regAddr_t rt;
        regAddr_t rd;
        regAddr_t shamt;
        funct_t   funct;
        exCtrl_t  ex;
        memCtrl_t mem;
        wbCtrl_t  wb;
    } idEx_t;

    typedef struct packed {
        word_t    branchTarget;
        logic     zero;
        word_t    aluResult;
        word_t    storeData;
        regAddr_t dest;
        memCtrl_t mem;
        wbCtrl_t  wb;
    } exMem_t;

    typedef struct packed {
        word_t    aluResult;
        word_t    loadData;
        regAddr_t dest;
        wbCtrl_t  wb;
    } memWb_t;

endpackage

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCpu_config.svh"

module regFile
    import mipsPkg::*;
(
    input  wire logic     i_clk,
    input  wire logic     i_arstN,
    input  wire regAddr_t i_rsAddr,
    input  wire regAddr_t i_rtAddr,
    input  wire logic     i_wrEn,
    input  wire regAddr_t i_wrAddr,
    input  wire word_t    i_wrData,
    output word_t         o_rsData,
    output word_t         o_rtData
);

    word_t regs [`NUM_REGS];
    logic  wrLive;

    // r0 never takes a write
    assign wrLive = i_wrEn && (i_wrAddr != '0);

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[i_wrAddr] <= i_wrData;
        end
    end

    // Same-cycle write shows up on the read ports
    assign o_rsData = (wrLive && i_wrAddr == i_rsAddr) ? i_wrData : regs[i_rsAddr];
    assign o_rtData = (wrLive && i_wrAddr == i_rtAddr) ? i_wrData : regs[i_rtAddr];

endmodule

`default_nettype wire

//--- runSim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tbMipsCpu -f mipsCpu.f -o simMipsCpu \
    && ./obj_dir/simMipsCpu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx "TB PASSED" sim.log && exit 0 || exit 1

//--- tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    input  wire logic i_rstReq,
    output logic      o_clk,
    output logic      o_arstN
);

    logic powerOnDone;

    // 8 ns period
    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // Power-on reset for four cycles, released on a falling edge
    initial begin
        powerOnDone = 1'b0;
        repeat (4) @(negedge o_clk);
        powerOnDone = 1'b1;
    end

    assign o_arstN = powerOnDone && !i_rstReq;

endmodule

`default_nettype wire

//--- tbMipsCpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCpu_config.svh"

module tbMipsCpu
    import mipsPkg::*;
();

    typedef struct packed {
        regAddr_t dest;
        word_t    data;
    } wbRec_t;

    logic      clk;
    logic      arstN;
    logic      rstReq;
    logic      run;
    logic      imemWe;
    imemAddr_t imemAddr;
    word_t     imemData;
    logic      wbValid;
    regAddr_t  wbReg;
    word_t     wbData;

    word_t  prog [$];
    wbRec_t expQ [$];
    wbRec_t gotQ [$];
    word_t  model [`NUM_REGS];
    word_t  memModel [word_t];
    logic   skipping;
    logic   collecting;
    word_t  seed;
    int     budget = 40;
    int     cycles;
    int     checks;
    int     errors;
    int     testsRun;

    tbClock uClock (
        .i_rstReq (rstReq),
        .o_clk    (clk),
        .o_arstN  (arstN)
    );

    mipsCpu uut (
        .i_clk      (clk),
        .i_arstN    (arstN),
        .i_run      (run),
        .i_imemWe   (imemWe),
        .i_imemAddr (imemAddr),
        .i_imemData (imemData),
        .o_wbValid  (wbValid),
        .o_wbReg    (wbReg),
        .o_wbData   (wbData)
    );

    // Writeback port is registered, so the rising edge sees last cycle's value
    always @(posedge clk) begin
        if (wbValid) begin
            if (collecting) begin
                gotQ.push_back({wbReg, wbData});
            end else begin
                errors++;
                $display("Writeback pulse to r%0d at %0t while in reset or halted", wbReg, $time);
            end
        end
    end

    // Watchdog whose budget grows as each test sizes its program
    initial begin
        cycles = 0;
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("Watchdog expired after %0d cycles", cycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic word_t nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks

    task automatic checkWord(string sig, word_t expected, word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %08h actual %08h", $time, sig, expected, actual);
        end
    endtask

    task automatic checkReg(string sig, regAddr_t expected, regAddr_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected r%0d actual r%0d", $time, sig, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Program builder with an ISA reference model

    task automatic startProgram();
        prog.delete();
        expQ.delete();
        skipping = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model[i] = '0;
        end
    endtask

    // Skipped instructions and r0 writes never retire
    task automatic retire(regAddr_t rd, word_t val);
        if (!skipping && rd != '0) begin
            model[rd] = val;
            expQ.push_back({rd, val});
        end
    endtask

    task automatic emitR(funct_t fn, regAddr_t rd, regAddr_t rs, regAddr_t rt, logic [4:0] sh);
        word_t a;
        word_t b;
        word_t r;
        a = model[rs];
        b = model[rt];
        case (fn)
            FN_ADD:  r = a + b;
            FN_SUB:  r = a - b;
            FN_AND:  r = a & b;
            FN_OR:   r = a | b;
            FN_XOR:  r = a ^ b;
            FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLL:  r = b << sh;
            FN_SRL:  r = b >> sh;
            default: r = '0;
        endcase
        prog.push_back({OP_RTYPE, rs, rt, rd, sh, fn});
        retire(rd, r);
    endtask

    // Arguments in assembly order op rt, rs, imm
    task automatic emitI(opcode_t op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
        word_t sext;
        word_t zext;
        word_t addr;
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        addr = model[rs] + sext;
        prog.push_back({op, rs, rt, imm});
        case (op)
            OP_ADDI: retire(rt, model[rs] + sext);
            OP_ANDI: retire(rt, model[rs] & zext);
            OP_ORI:  retire(rt, model[rs] | zext);
            OP_LW:   retire(rt, memModel[addr]);
            OP_SW: begin
                if (!skipping) begin
                    memModel[addr] = model[rt];
                end
            end
            default: ;
        endcase
    endtask

    task automatic emitJump(int targetIdx);
        logic [25:0] idx;
        idx = 26'(targetIdx);
        prog.push_back({OP_J, idx});
    endtask

    // Full 32-bit values with each step three slots after the last
    task automatic seedRegisters(regAddr_t ra, regAddr_t rb, regAddr_t rc);
        word_t    v [3];
        regAddr_t r [3];
        r[0] = ra;
        r[1] = rb;
        r[2] = rc;
        for (int i = 0; i < 3; i++) begin
            v[i] = nextRand();
        end
        for (int i = 0; i < 3; i++) begin
            emitI(OP_ADDI, r[i], 5'd0, v[i][31:16]);
        end
        for (int i = 0; i < 3; i++) begin
            emitR(FN_SLL, r[i], 5'd0, r[i], 5'd16);
        end
        for (int i = 0; i < 3; i++) begin
            emitI(OP_ORI, r[i], r[i], v[i][15:0]);
        end
    endtask

    //////////////////////////////////////////////////
    // Load, reset, run and compare

    task automatic runProgram(string name, int idleCycles, logic resetBusy);
        int errBefore;
        int waited;
        int n;
        errBefore = errors;
        repeat (16) prog.push_back('0);
        budget += 2 * prog.size() + idleCycles + (resetBusy ? 8 : 0) + 30;

        foreach (prog[i]) begin
            @(negedge clk);
            imemWe   = 1'b1;
            imemAddr = imemAddr_t'(i);
            imemData = prog[i];
        end
        @(negedge clk);
        imemWe = 1'b0;
        if (resetBusy) begin
            rstReq = 1'b1;
            repeat (4) @(negedge clk);
            rstReq = 1'b0;
            run    = 1'b1;
            // First instruction now sits in MEM/WB and reset must hide it
            repeat (4) @(negedge clk);
            run    = 1'b0;
        end
        rstReq = 1'b1;
        repeat (4) @(negedge clk);
        rstReq = 1'b0;
        repeat (idleCycles) @(negedge clk);

        gotQ.delete();
        collecting = 1'b1;
        run        = 1'b1;
        waited     = 0;
        while (gotQ.size() < expQ.size() && waited < prog.size() + 10) begin
            @(negedge clk);
            waited++;
        end
        // Extra cycles expose stray retirements
        repeat (6) @(negedge clk);
        run = 1'b0;
        repeat (5) @(negedge clk);
        collecting = 1'b0;

        n = (gotQ.size() < expQ.size()) ? gotQ.size() : expQ.size();
        if (gotQ.size() < expQ.size()) begin
            errors++;
            $display("%s: only %0d of %0d expected writebacks arrived",
                     name, gotQ.size(), expQ.size());
        end else if (gotQ.size() > expQ.size()) begin
            errors++;
            $display("%s: %0d writebacks arrived where %0d were expected",
                     name, gotQ.size(), expQ.size());
        end
        for (int i = 0; i < n; i++) begin
            checkReg($sformatf("o_wbReg #%0d", i), expQ[i].dest, gotQ[i].dest);
            checkWord($sformatf("o_wbData #%0d", i), expQ[i].data, gotQ[i].data);
        end
        testsRun++;
        $display("%s: %0d writebacks, %s", name, gotQ.size(),
                 (errors == errBefore) ? "ok" : "mismatches");
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic testRType();
        word_t rnd;
        rnd = nextRand();
        startProgram();
        seedRegisters(5'd1, 5'd2, 5'd3);
        emitR(FN_SLL, 5'd17, 5'd0, 5'd1, rnd[4:0]);
        emitR(FN_ADD, 5'd10, 5'd1, 5'd2, 5'd0);
        emitR(FN_SUB, 5'd11, 5'd1, 5'd3, 5'd0);
        emitR(FN_AND, 5'd12, 5'd2, 5'd3, 5'd0);
        emitR(FN_OR,  5'd13, 5'd1, 5'd3, 5'd0);
        emitR(FN_XOR, 5'd14, 5'd2, 5'd1, 5'd0);
        emitR(FN_SLT, 5'd15, 5'd1, 5'd2, 5'd0);
        emitR(FN_SRL, 5'd16, 5'd0, 5'd3, rnd[12:8]);
        runProgram("rtype", 0, 1'b0);
    endtask

    task automatic testImmediates();
        word_t rnd;
        rnd = nextRand();
        startProgram();
        emitI(OP_ADDI, 5'd1, 5'd0, 16'hFFFF);
        emitI(OP_ADDI, 5'd2, 5'd0, rnd[15:0] | 16'h8000);
        emitI(OP_ORI,  5'd3, 5'd0, rnd[31:16] | 16'h8000);
        emitI(OP_ANDI, 5'd4, 5'd1, rnd[31:16] | 16'h8000);
        emitI(OP_ADDI, 5'd5, 5'd1, rnd[15:0] | 16'h8000);
        emitI(OP_ADDI, 5'd6, 5'd2, rnd[31:16] | 16'h8000);
        runProgram("immediate", 0, 1'b0);
    endtask

    task automatic testMemory();
        startProgram();
        emitI(OP_ADDI, 5'd1, 5'd0, 16'h0100);
        seedRegisters(5'd2, 5'd3, 5'd4);
        emitI(OP_SW, 5'd2, 5'd1, 16'h0000);
        emitI(OP_SW, 5'd3, 5'd1, 16'h0008);
        emitI(OP_SW, 5'd4, 5'd1, 16'hFFFC);
        emitI(OP_LW, 5'd5, 5'd1, 16'h0000);
        emitI(OP_LW, 5'd6, 5'd1, 16'h0008);
        emitI(OP_LW, 5'd7, 5'd1, 16'hFFFC);
        runProgram("memory", 0, 1'b0);
    endtask

    task automatic testBranch();
        word_t rnd;
        rnd = nextRand();
        startProgram();
        emitI(OP_ADDI, 5'd4, 5'd0, rnd[15:0]);
        emitI(OP_ADDI, 5'd5, 5'd0, rnd[15:0] ^ 16'h0001);
        emitI(OP_ADDI, 5'd6, 5'd0, rnd[31:16]);
        emitI(OP_ADDI, 5'd7, 5'd4, 16'd3);
        // Not taken so everything after it retires
        emitI(OP_BEQ, 5'd5, 5'd4, 16'd5);
        for (int i = 8; i < 13; i++) begin
            emitI(OP_ADDI, regAddr_t'(i), 5'd6, 16'(i));
        end
        // Taken with three slots run and two skipped
        emitI(OP_BEQ, 5'd4, 5'd4, 16'd5);
        emitI(OP_ADDI, 5'd13, 5'd6, 16'd13);
        emitI(OP_ADDI, 5'd14, 5'd6, 16'd14);
        emitI(OP_ADDI, 5'd15, 5'd6, 16'd15);
        skipping = 1'b1;
        emitI(OP_ADDI, 5'd16, 5'd6, 16'd16);
        emitI(OP_ADDI, 5'd17, 5'd6, 16'd17);
        skipping = 1'b0;
        emitI(OP_ADDI, 5'd18, 5'd7, 16'd1);
        emitR(FN_ADD, 5'd19, 5'd13, 5'd8, 5'd0);
        runProgram("branch", 0, 1'b0);
    endtask

    task automatic testJump();
        word_t rnd;
        rnd = nextRand();
        startProgram();
        emitI(OP_ADDI, 5'd1, 5'd0, rnd[15:0]);
        emitJump(5);
        emitI(OP_ADDI, 5'd2, 5'd0, 16'd2);
        skipping = 1'b1;
        emitI(OP_ADDI, 5'd3, 5'd0, 16'd3);
        emitI(OP_ADDI, 5'd4, 5'd0, 16'd4);
        skipping = 1'b0;
        emitI(OP_ADDI, 5'd5, 5'd1, 16'd5);
        emitR(FN_ADD, 5'd6, 5'd1, 5'd1, 5'd0);
        runProgram("jump", 0, 1'b0);
    endtask

    task automatic testRunControl();
        word_t rnd;
        rnd = nextRand();
        startProgram();
        // Held at address zero this would pulse if fetch did not bubble
        emitI(OP_ADDI, 5'd7, 5'd0, rnd[31:16]);
        emitI(OP_ADDI, 5'd0, 5'd0, rnd[15:0] | 16'h0001);
        emitI(OP_ORI,  5'd0, 5'd0, 16'h00FF);
        prog.push_back('0);
        prog.push_back('0);
        // r0 must still read as zero
        emitI(OP_ADDI, 5'd8, 5'd0, 16'd5);
        emitR(FN_OR, 5'd9, 5'd0, 5'd0, 5'd0);
        runProgram("runctrl", 8, 1'b1);
    endtask

    initial begin
        seed       = 32'h7045;
        rstReq     = 1'b0;
        run        = 1'b0;
        imemWe     = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        collecting = 1'b0;
        skipping   = 1'b0;
        checks     = 0;
        errors     = 0;
        testsRun   = 0;
        wait (arstN === 1'b1);
        @(negedge clk);

        testRType();
        testImmediates();
        testMemory();
        testBranch();
        testJump();
        testRunControl();

        $display("Tests run %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
